// File: hw/rv_isa_pkg.sv
//----------------------------------------------------------
// RISC-V base ISA encodings used by the multicycle core:
// opcodes, funct codes, manager CSR numbers, field widths
//----------------------------------------------------------

package rv_isa_pkg;

  localparam int INST_W   = 32;
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;
  localparam int CSR_W    = 12;

  typedef logic [INST_W-1:0]   inst_t;
  typedef logic [OPCODE_W-1:0] opcode_t;
  typedef logic [FUNCT3_W-1:0] funct3_t;
  typedef logic [FUNCT7_W-1:0] funct7_t;
  typedef logic [CSR_W-1:0]    csr_addr_t;

  //----------------------------------------------------------
  // Major opcodes
  //----------------------------------------------------------
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  // Arithmetic and logic funct3, shared by OP and OP-IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // Branch and jump funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;
  localparam funct3_t F3_JALR = 3'b000;

  // CSRW is csrrw x0, CSRR is csrrs with rs1 = x0
  localparam funct3_t F3_CSRRW = 3'b001;
  localparam funct3_t F3_CSRRS = 3'b010;

  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_ALT  = 7'b0100000;

  localparam csr_addr_t CSR_MNGR2PROC = 12'hfc0;
  localparam csr_addr_t CSR_PROC2MNGR = 12'h7c0;

endpackage

// File: hw/proc_pkg.sv
//----------------------------------------------------------
// Datapath types and control encodings of the core
//----------------------------------------------------------

package proc_pkg;

  localparam int WORD_W    = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
    ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
  } cmp_op_e;

  typedef enum logic {OPA_RS1, OPA_PC} opa_sel_e;
  typedef enum logic {OPB_RS2, OPB_IMM} opb_sel_e;

  typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;
  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_PC4, WB_MNGR} wb_sel_e;
  typedef enum logic [1:0] {CSR_NONE, CSR_READ_MNGR, CSR_WRITE_MNGR} csr_op_e;

  // One instruction walks IDLE -> IREQ -> IWAIT -> EXEC
  typedef enum logic [1:0] {ST_IDLE, ST_IREQ, ST_IWAIT, ST_EXEC} ctrl_state_e;

endpackage

// File: hw/inst_decoder.sv
//----------------------------------------------------------
// Instruction decoder: fields, immediates, control codes
//----------------------------------------------------------
`timescale 1ns/1ps

module inst_decoder (
  input  rv_isa_pkg::inst_t    inst_i,
  output proc_pkg::reg_idx_t   rs1_o,
  output proc_pkg::reg_idx_t   rs2_o,
  output proc_pkg::reg_idx_t   rd_o,
  output proc_pkg::word_t      imm_o,
  output proc_pkg::alu_op_e    alu_op_o,
  output proc_pkg::cmp_op_e    cmp_op_o,
  output proc_pkg::opa_sel_e   opa_sel_o,
  output proc_pkg::opb_sel_e   opb_sel_o,
  output proc_pkg::pc_sel_e    pc_sel_o,
  output proc_pkg::wb_sel_e    wb_sel_o,
  output proc_pkg::csr_op_e    csr_op_o
);

  rv_isa_pkg::opcode_t   opcode;
  rv_isa_pkg::funct3_t   funct3;
  rv_isa_pkg::funct7_t   funct7;
  rv_isa_pkg::csr_addr_t csr;
  logic                  funct7_ok;
  proc_pkg::word_t       imm_i_type;
  proc_pkg::word_t       imm_b_type;
  proc_pkg::word_t       imm_u_type;
  proc_pkg::word_t       imm_j_type;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign csr    = inst_i[31:20];
  assign rd_o   = inst_i[11:7];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  // Sign-extended immediates
  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};

  // Only SUB, SRA and SRAI may set funct7 bit 5
  assign funct7_ok = (funct7 == rv_isa_pkg::F7_BASE) ||
                     ((funct7 == rv_isa_pkg::F7_ALT) &&
                      (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                       funct3 == rv_isa_pkg::F3_SRL_SRA));

  always_comb begin
    // Defaults describe a no-op
    imm_o     = '0;
    alu_op_o  = proc_pkg::ALU_ADD;
    cmp_op_o  = proc_pkg::CMP_EQ;
    opa_sel_o = proc_pkg::OPA_RS1;
    opb_sel_o = proc_pkg::OPB_RS2;
    pc_sel_o  = proc_pkg::PC_PLUS4;
    wb_sel_o  = proc_pkg::WB_NONE;
    csr_op_o  = proc_pkg::CSR_NONE;

    case (opcode)
      rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
        wb_sel_o = proc_pkg::WB_ALU;
        if (opcode == rv_isa_pkg::OPC_OP_IMM) begin
          opb_sel_o = proc_pkg::OPB_IMM;
          imm_o     = imm_i_type;
        end
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB:
            alu_op_o = (opcode == rv_isa_pkg::OPC_OP && funct7 == rv_isa_pkg::F7_ALT) ?
                       proc_pkg::ALU_SUB : proc_pkg::ALU_ADD;
          rv_isa_pkg::F3_SLL:  alu_op_o = proc_pkg::ALU_SLL;
          rv_isa_pkg::F3_SLT:  alu_op_o = proc_pkg::ALU_SLT;
          rv_isa_pkg::F3_SLTU: alu_op_o = proc_pkg::ALU_SLTU;
          rv_isa_pkg::F3_XOR:  alu_op_o = proc_pkg::ALU_XOR;
          rv_isa_pkg::F3_OR:   alu_op_o = proc_pkg::ALU_OR;
          rv_isa_pkg::F3_AND:  alu_op_o = proc_pkg::ALU_AND;
          default:
            alu_op_o = (funct7 == rv_isa_pkg::F7_ALT) ? proc_pkg::ALU_SRA : proc_pkg::ALU_SRL;
        endcase
        // funct7 is checked for register ops and immediate shifts only
        if ((opcode == rv_isa_pkg::OPC_OP || funct3 == rv_isa_pkg::F3_SLL ||
             funct3 == rv_isa_pkg::F3_SRL_SRA) && !funct7_ok) begin
          wb_sel_o = proc_pkg::WB_NONE;
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        alu_op_o  = proc_pkg::ALU_PASS_B;
        opb_sel_o = proc_pkg::OPB_IMM;
        imm_o     = imm_u_type;
        wb_sel_o  = proc_pkg::WB_ALU;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        opa_sel_o = proc_pkg::OPA_PC;
        opb_sel_o = proc_pkg::OPB_IMM;
        imm_o     = imm_u_type;
        wb_sel_o  = proc_pkg::WB_ALU;
      end
      rv_isa_pkg::OPC_JAL: begin
        imm_o    = imm_j_type;
        pc_sel_o = proc_pkg::PC_JAL;
        wb_sel_o = proc_pkg::WB_PC4;
      end
      rv_isa_pkg::OPC_JALR: begin
        if (funct3 == rv_isa_pkg::F3_JALR) begin
          opb_sel_o = proc_pkg::OPB_IMM;
          imm_o     = imm_i_type;
          pc_sel_o  = proc_pkg::PC_JALR;
          wb_sel_o  = proc_pkg::WB_PC4;
        end
      end
      rv_isa_pkg::OPC_BRANCH: begin
        imm_o    = imm_b_type;
        pc_sel_o = proc_pkg::PC_BRANCH;
        case (funct3)
          rv_isa_pkg::F3_BEQ:  cmp_op_o = proc_pkg::CMP_EQ;
          rv_isa_pkg::F3_BNE:  cmp_op_o = proc_pkg::CMP_NE;
          rv_isa_pkg::F3_BLT:  cmp_op_o = proc_pkg::CMP_LT;
          rv_isa_pkg::F3_BGE:  cmp_op_o = proc_pkg::CMP_GE;
          rv_isa_pkg::F3_BLTU: cmp_op_o = proc_pkg::CMP_LTU;
          rv_isa_pkg::F3_BGEU: cmp_op_o = proc_pkg::CMP_GEU;
          default:             pc_sel_o = proc_pkg::PC_PLUS4;
        endcase
      end
      rv_isa_pkg::OPC_SYSTEM: begin
        if (funct3 == rv_isa_pkg::F3_CSRRS && csr == rv_isa_pkg::CSR_MNGR2PROC &&
            rs1_o == '0) begin
          csr_op_o = proc_pkg::CSR_READ_MNGR;
          wb_sel_o = proc_pkg::WB_MNGR;
        end else if (funct3 == rv_isa_pkg::F3_CSRRW &&
                     csr == rv_isa_pkg::CSR_PROC2MNGR && rd_o == '0) begin
          csr_op_o = proc_pkg::CSR_WRITE_MNGR;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// File: hw/alu.sv
//----------------------------------------------------------
// ALU with a separate branch compare output
//----------------------------------------------------------
`timescale 1ns/1ps

module alu (
  input  proc_pkg::word_t   op_a_i,
  input  proc_pkg::word_t   op_b_i,
  input  proc_pkg::word_t   cmp_b_i,
  input  proc_pkg::alu_op_e alu_op_i,
  input  proc_pkg::cmp_op_e cmp_op_i,
  output proc_pkg::word_t   result_o,
  output logic              cond_o
);

  logic [4:0] shamt;

  assign shamt = op_b_i[4:0];

  always_comb begin
    case (alu_op_i)
      proc_pkg::ALU_ADD:    result_o = op_a_i + op_b_i;
      proc_pkg::ALU_SUB:    result_o = op_a_i - op_b_i;
      proc_pkg::ALU_AND:    result_o = op_a_i & op_b_i;
      proc_pkg::ALU_OR:     result_o = op_a_i | op_b_i;
      proc_pkg::ALU_XOR:    result_o = op_a_i ^ op_b_i;
      proc_pkg::ALU_SLT:
        result_o = proc_pkg::word_t'($signed(op_a_i) < $signed(op_b_i));
      proc_pkg::ALU_SLTU:   result_o = proc_pkg::word_t'(op_a_i < op_b_i);
      proc_pkg::ALU_SLL:    result_o = op_a_i << shamt;
      proc_pkg::ALU_SRL:    result_o = op_a_i >> shamt;
      proc_pkg::ALU_SRA:    result_o = $signed(op_a_i) >>> shamt;
      proc_pkg::ALU_PASS_B: result_o = op_b_i;
      default:              result_o = op_a_i + op_b_i;
    endcase
  end

  // Branches decode operand a as rs1, cmp_b_i is always rs2
  always_comb begin
    case (cmp_op_i)
      proc_pkg::CMP_EQ:  cond_o = (op_a_i == cmp_b_i);
      proc_pkg::CMP_NE:  cond_o = (op_a_i != cmp_b_i);
      proc_pkg::CMP_LT:  cond_o = ($signed(op_a_i) < $signed(cmp_b_i));
      proc_pkg::CMP_GE:  cond_o = ($signed(op_a_i) >= $signed(cmp_b_i));
      proc_pkg::CMP_LTU: cond_o = (op_a_i < cmp_b_i);
      proc_pkg::CMP_GEU: cond_o = (op_a_i >= cmp_b_i);
      default:           cond_o = 1'b0;
    endcase
  end

endmodule

// File: hw/reg_file.sv
//----------------------------------------------------------
// 32 x 32 register file, two read ports, x0 tied to zero
//----------------------------------------------------------
`timescale 1ns/1ps

module reg_file (
  input  logic               clk,
  input  logic               reset,
  input  proc_pkg::reg_idx_t raddr1_i,
  input  proc_pkg::reg_idx_t raddr2_i,
  input  logic               wen_i,
  input  proc_pkg::reg_idx_t waddr_i,
  input  proc_pkg::word_t    wdata_i,
  output proc_pkg::word_t    rdata1_o,
  output proc_pkg::word_t    rdata2_o
);

  proc_pkg::word_t regs [proc_pkg::NUM_REGS];

  // x0 is cleared by reset and never written afterwards
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < proc_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

  // Holds only if the write filter has kept x0 clear since reset
  a_x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
    (raddr1_i == '0 |-> rdata1_o == '0) and (raddr2_i == '0 |-> rdata2_o == '0));

endmodule

// File: hw/proc_ctrl.sv
//----------------------------------------------------------
// Multicycle control: fetch/execute FSM, PC, write-back
// and the handshakes on the memory and manager streams
//----------------------------------------------------------
`timescale 1ns/1ps

module proc_ctrl #(
  parameter proc_pkg::word_t P_RESET_PC = 32'h200
) (
  input  logic                clk,
  input  logic                reset,
  // Instruction memory
  output logic                imem_req_val_o,
  output proc_pkg::word_t     imem_req_addr_o,
  input  logic                imem_req_rdy_i,
  input  logic                imem_resp_val_i,
  input  rv_isa_pkg::inst_t   imem_resp_data_i,
  output logic                imem_resp_rdy_o,
  // Manager streams
  input  logic                mngr2proc_val_i,
  input  proc_pkg::word_t     mngr2proc_msg_i,
  output logic                mngr2proc_rdy_o,
  output logic                proc2mngr_val_o,
  output proc_pkg::word_t     proc2mngr_msg_o,
  input  logic                proc2mngr_rdy_i,
  // Decoded controls
  input  proc_pkg::reg_idx_t  rd_i,
  input  proc_pkg::word_t     imm_i,
  input  proc_pkg::opa_sel_e  opa_sel_i,
  input  proc_pkg::opb_sel_e  opb_sel_i,
  input  proc_pkg::pc_sel_e   pc_sel_i,
  input  proc_pkg::wb_sel_e   wb_sel_i,
  input  proc_pkg::csr_op_e   csr_op_i,
  // Register file and ALU
  input  proc_pkg::word_t     rs1_data_i,
  input  proc_pkg::word_t     rs2_data_i,
  input  proc_pkg::word_t     alu_result_i,
  input  logic                cond_i,
  output rv_isa_pkg::inst_t   inst_o,
  output proc_pkg::word_t     op_a_o,
  output proc_pkg::word_t     op_b_o,
  output logic                rf_wen_o,
  output proc_pkg::reg_idx_t  rf_waddr_o,
  output proc_pkg::word_t     rf_wdata_o
);

  proc_pkg::ctrl_state_e state;
  proc_pkg::ctrl_state_e state_next;
  proc_pkg::word_t       pc;
  proc_pkg::word_t       pc_next;
  proc_pkg::word_t       pc_plus4;
  proc_pkg::word_t       pc_target;
  rv_isa_pkg::inst_t     inst_reg;
  logic                  exec;
  logic                  stall;
  logic                  retire;

  //----------------------------------------------------------
  // Stream handshakes
  //----------------------------------------------------------
  assign exec            = (state == proc_pkg::ST_EXEC);
  assign imem_req_val_o  = (state == proc_pkg::ST_IREQ);
  assign imem_req_addr_o = pc;
  assign imem_resp_rdy_o = (state == proc_pkg::ST_IWAIT);
  assign mngr2proc_rdy_o = exec && (csr_op_i == proc_pkg::CSR_READ_MNGR);
  assign proc2mngr_val_o = exec && (csr_op_i == proc_pkg::CSR_WRITE_MNGR);
  assign proc2mngr_msg_o = rs1_data_i;

  // EXEC waits on whichever manager stream the CSR op uses
  assign stall  = (mngr2proc_rdy_o && !mngr2proc_val_i) ||
                  (proc2mngr_val_o && !proc2mngr_rdy_i);
  assign retire = exec && !stall;

  //----------------------------------------------------------
  // Operands, next PC and write-back
  //----------------------------------------------------------
  assign inst_o    = inst_reg;
  assign op_a_o    = (opa_sel_i == proc_pkg::OPA_PC) ? pc : rs1_data_i;
  assign op_b_o    = (opb_sel_i == proc_pkg::OPB_IMM) ? imm_i : rs2_data_i;
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm_i;

  always_comb begin
    case (pc_sel_i)
      proc_pkg::PC_BRANCH: pc_next = cond_i ? pc_target : pc_plus4;
      proc_pkg::PC_JAL:    pc_next = pc_target;
      proc_pkg::PC_JALR:   pc_next = {alu_result_i[31:1], 1'b0};
      default:             pc_next = pc_plus4;
    endcase
  end

  always_comb begin
    case (wb_sel_i)
      proc_pkg::WB_PC4:  rf_wdata_o = pc_plus4;
      proc_pkg::WB_MNGR: rf_wdata_o = mngr2proc_msg_i;
      default:           rf_wdata_o = alu_result_i;
    endcase
  end

  assign rf_wen_o   = retire && (wb_sel_i != proc_pkg::WB_NONE);
  assign rf_waddr_o = rd_i;

  //----------------------------------------------------------
  // FSM and PC
  //----------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      proc_pkg::ST_IDLE:  state_next = proc_pkg::ST_IREQ;
      proc_pkg::ST_IREQ:  if (imem_req_rdy_i) state_next = proc_pkg::ST_IWAIT;
      proc_pkg::ST_IWAIT: if (imem_resp_val_i) state_next = proc_pkg::ST_EXEC;
      default:            if (!stall) state_next = proc_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= proc_pkg::ST_IDLE;
      pc    <= P_RESET_PC;
    end else begin
      state <= state_next;
      if (retire) begin
        pc <= pc_next;
      end
    end
  end

  // Instruction register, loaded on the response transfer
  always_ff @(posedge clk) begin
    if (imem_resp_rdy_o && imem_resp_val_i) begin
      inst_reg <= imem_resp_data_i;
    end
  end

  // A stalled CSRW keeps its message on the port
  a_p2m_hold: assert property (@(posedge clk) disable iff (reset)
    proc2mngr_val_o && !proc2mngr_rdy_i |=> proc2mngr_val_o && $stable(proc2mngr_msg_o));

  // After a fetch transfer, IWAIT, EXEC and IDLE pass before the next request
  a_one_fetch: assert property (@(posedge clk) disable iff (reset)
    imem_req_val_o && imem_req_rdy_i |=> !imem_req_val_o [*3]);

endmodule

// File: hw/proc_top.sv
//----------------------------------------------------------
// Multicycle RISC-V core top level
//----------------------------------------------------------
`timescale 1ns/1ps

module proc_top #(
  parameter proc_pkg::word_t P_RESET_PC = 32'h200
) (
  input  logic              clk,
  input  logic              reset,
  output logic              imem_req_val_o,
  output proc_pkg::word_t   imem_req_addr_o,
  input  logic              imem_req_rdy_i,
  input  logic              imem_resp_val_i,
  input  rv_isa_pkg::inst_t imem_resp_data_i,
  output logic              imem_resp_rdy_o,
  input  logic              mngr2proc_val_i,
  input  proc_pkg::word_t   mngr2proc_msg_i,
  output logic              mngr2proc_rdy_o,
  output logic              proc2mngr_val_o,
  output proc_pkg::word_t   proc2mngr_msg_o,
  input  logic              proc2mngr_rdy_i
);

  rv_isa_pkg::inst_t  inst;
  proc_pkg::reg_idx_t rs1;
  proc_pkg::reg_idx_t rs2;
  proc_pkg::reg_idx_t rd;
  proc_pkg::word_t    imm;
  proc_pkg::alu_op_e  alu_op;
  proc_pkg::cmp_op_e  cmp_op;
  proc_pkg::opa_sel_e opa_sel;
  proc_pkg::opb_sel_e opb_sel;
  proc_pkg::pc_sel_e  pc_sel;
  proc_pkg::wb_sel_e  wb_sel;
  proc_pkg::csr_op_e  csr_op;
  proc_pkg::word_t    rs1_data;
  proc_pkg::word_t    rs2_data;
  proc_pkg::word_t    op_a;
  proc_pkg::word_t    op_b;
  proc_pkg::word_t    alu_result;
  logic               cond;
  logic               rf_wen;
  proc_pkg::reg_idx_t rf_waddr;
  proc_pkg::word_t    rf_wdata;

  inst_decoder u_decoder (
    .inst_i(inst), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
    .alu_op_o(alu_op), .cmp_op_o(cmp_op), .opa_sel_o(opa_sel), .opb_sel_o(opb_sel),
    .pc_sel_o(pc_sel), .wb_sel_o(wb_sel), .csr_op_o(csr_op)
  );

  // Compare input takes rs2 straight from the register file
  alu u_alu (
    .op_a_i(op_a), .op_b_i(op_b), .cmp_b_i(rs2_data), .alu_op_i(alu_op),
    .cmp_op_i(cmp_op), .result_o(alu_result), .cond_o(cond)
  );

  reg_file u_reg_file (
    .clk(clk), .reset(reset), .raddr1_i(rs1), .raddr2_i(rs2), .wen_i(rf_wen),
    .waddr_i(rf_waddr), .wdata_i(rf_wdata), .rdata1_o(rs1_data), .rdata2_o(rs2_data)
  );

  proc_ctrl #(.P_RESET_PC(P_RESET_PC)) u_ctrl (
    .clk(clk), .reset(reset),
    .imem_req_val_o(imem_req_val_o), .imem_req_addr_o(imem_req_addr_o),
    .imem_req_rdy_i(imem_req_rdy_i), .imem_resp_val_i(imem_resp_val_i),
    .imem_resp_data_i(imem_resp_data_i), .imem_resp_rdy_o(imem_resp_rdy_o),
    .mngr2proc_val_i(mngr2proc_val_i), .mngr2proc_msg_i(mngr2proc_msg_i),
    .mngr2proc_rdy_o(mngr2proc_rdy_o), .proc2mngr_val_o(proc2mngr_val_o),
    .proc2mngr_msg_o(proc2mngr_msg_o), .proc2mngr_rdy_i(proc2mngr_rdy_i),
    .rd_i(rd), .imm_i(imm), .opa_sel_i(opa_sel), .opb_sel_i(opb_sel),
    .pc_sel_i(pc_sel), .wb_sel_i(wb_sel), .csr_op_i(csr_op),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .alu_result_i(alu_result),
    .cond_i(cond), .inst_o(inst), .op_a_o(op_a), .op_b_o(op_b),
    .rf_wen_o(rf_wen), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata)
  );

endmodule

// File: verification/tb_clk_gen.sv
//----------------------------------------------------------
// Testbench clock and synchronous reset generator
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int P_HALF_PERIOD  = 10,
  parameter int P_RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(P_HALF_PERIOD) clk_o = ~clk_o;
  end

  // Released just after an edge, like the other inputs
  initial begin
    reset_o = 1'b1;
    repeat (P_RESET_CYCLES) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

// File: verification/proc_top_tb.sv
//----------------------------------------------------------
// Testbench for the multicycle core with a program table,
// memory and manager stream models and in-order output checks
//----------------------------------------------------------
`timescale 1ns/1ps

module proc_top_tb;

  localparam proc_pkg::word_t RESET_PC = 32'h200;
  localparam int NUM_INSTS  = 80;
  localparam int NUM_SRC    = 2;
  localparam int NUM_OUTS   = 30;
  localparam int NUM_JUMPS  = 9;
  localparam int MAX_CYCLES = NUM_INSTS * 16 + 100;

  logic              clk;
  logic              reset;
  logic              imem_req_val;
  proc_pkg::word_t   imem_req_addr;
  logic              imem_req_rdy;
  logic              imem_resp_val;
  rv_isa_pkg::inst_t imem_resp_data;
  logic              imem_resp_rdy;
  logic              mngr2proc_val;
  proc_pkg::word_t   mngr2proc_msg;
  logic              mngr2proc_rdy;
  logic              proc2mngr_val;
  proc_pkg::word_t   proc2mngr_msg;
  logic              proc2mngr_rdy;

  rv_isa_pkg::inst_t prog [NUM_INSTS];

  // A negative word and a word whose low 5 bits give a shift of 4
  proc_pkg::word_t mngr_in [NUM_SRC] = '{32'hf000_0f0f, 32'h0000_0024};

  proc_pkg::word_t exp_out [NUM_OUTS] = '{
    // ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
    32'hf000_0f33, 32'hf000_0eeb, 32'h0000_0004, 32'hf000_0f2f, 32'hf000_0f2b,
    32'h0000_0001, 32'h0000_0000, 32'h0000_f0f0, 32'h0f00_00f0, 32'hff00_00f0,
    // ADDI ANDI ORI XORI SLTI SLTIU SLLI SRLI SRAI LUI AUIPC and the x0 check
    32'hffff_fffb, 32'hf000_0f00, 32'h0000_0124, 32'h0fff_f0f0, 32'h0000_0001,
    32'h0000_0001, 32'h0000_0120, 32'h00f0_000f, 32'hfff0_000f, 32'h1234_5000,
    32'h0000_12a8, 32'h0000_0000,
    // Fall-through marker of each not-taken branch
    32'h0000_00f1, 32'h0000_00f1, 32'h0000_00f1, 32'h0000_00f1, 32'h0000_00f1,
    32'h0000_00f1,
    // Links of the JAL at 0x320 and the JALR at 0x330
    32'h0000_0324, 32'h0000_0334
  };

  // Taken branches and jumps of the program and the address each fetches next
  proc_pkg::word_t jump_from [NUM_JUMPS] = '{
    32'h0000_02c0, 32'h0000_02d0, 32'h0000_02e0, 32'h0000_02f0, 32'h0000_0300,
    32'h0000_0310, 32'h0000_0320, 32'h0000_0330, 32'h0000_033c
  };
  proc_pkg::word_t jump_to [NUM_JUMPS] = '{
    32'h0000_02c8, 32'h0000_02d8, 32'h0000_02e8, 32'h0000_02f8, 32'h0000_0308,
    32'h0000_0318, 32'h0000_0328, 32'h0000_0338, 32'h0000_033c
  };

  tb_clk_gen #(.P_HALF_PERIOD(10), .P_RESET_CYCLES(3)) clk_gen (
    .clk_o(clk), .reset_o(reset)
  );

  proc_top #(.P_RESET_PC(RESET_PC)) dut0 (
    .clk(clk), .reset(reset),
    .imem_req_val_o(imem_req_val), .imem_req_addr_o(imem_req_addr),
    .imem_req_rdy_i(imem_req_rdy), .imem_resp_val_i(imem_resp_val),
    .imem_resp_data_i(imem_resp_data), .imem_resp_rdy_o(imem_resp_rdy),
    .mngr2proc_val_i(mngr2proc_val), .mngr2proc_msg_i(mngr2proc_msg),
    .mngr2proc_rdy_o(mngr2proc_rdy), .proc2mngr_val_o(proc2mngr_val),
    .proc2mngr_msg_o(proc2mngr_msg), .proc2mngr_rdy_i(proc2mngr_rdy)
  );

  //----------------------------------------------------------
  // Instruction encoders
  //----------------------------------------------------------
  function automatic rv_isa_pkg::inst_t reg_op(input rv_isa_pkg::funct7_t f7,
      input rv_isa_pkg::funct3_t f3, input proc_pkg::reg_idx_t rd,
      input proc_pkg::reg_idx_t rs1, input proc_pkg::reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
  endfunction

  function automatic rv_isa_pkg::inst_t imm_op(input rv_isa_pkg::funct3_t f3,
      input proc_pkg::reg_idx_t rd, input proc_pkg::reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
  endfunction

  function automatic rv_isa_pkg::inst_t shift_imm(input rv_isa_pkg::funct7_t f7,
      input rv_isa_pkg::funct3_t f3, input proc_pkg::reg_idx_t rd,
      input proc_pkg::reg_idx_t rs1, input logic [4:0] shamt);
    return {f7, shamt, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
  endfunction

  function automatic rv_isa_pkg::inst_t upper_imm(input rv_isa_pkg::opcode_t opc,
      input proc_pkg::reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // Offsets are byte offsets from the branch itself
  function automatic rv_isa_pkg::inst_t branch_op(input rv_isa_pkg::funct3_t f3,
      input proc_pkg::reg_idx_t rs1, input proc_pkg::reg_idx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_isa_pkg::inst_t jal_op(input proc_pkg::reg_idx_t rd,
      input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
  endfunction

  function automatic rv_isa_pkg::inst_t jalr_op(input proc_pkg::reg_idx_t rd,
      input proc_pkg::reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, rv_isa_pkg::F3_JALR, rd, rv_isa_pkg::OPC_JALR};
  endfunction

  function automatic rv_isa_pkg::inst_t read_mngr(input proc_pkg::reg_idx_t rd);
    return {rv_isa_pkg::CSR_MNGR2PROC, 5'd0, rv_isa_pkg::F3_CSRRS, rd, rv_isa_pkg::OPC_SYSTEM};
  endfunction

  function automatic rv_isa_pkg::inst_t write_mngr(input proc_pkg::reg_idx_t rs1);
    return {rv_isa_pkg::CSR_PROC2MNGR, rs1, rv_isa_pkg::F3_CSRRW, 5'd0, rv_isa_pkg::OPC_SYSTEM};
  endfunction

  // Fetch address that follows the instruction at addr
  function automatic proc_pkg::word_t next_fetch(input proc_pkg::word_t addr);
    proc_pkg::word_t target;
    target = addr + 32'd4;
    for (int i = 0; i < NUM_JUMPS; i++) begin
      if (jump_from[i] == addr) begin
        target = jump_to[i];
      end
    end
    return target;
  endfunction

  task automatic check_value(input string name, input proc_pkg::word_t actual,
                             input proc_pkg::word_t expected);
    if (actual !== expected) begin
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  //----------------------------------------------------------
  // Stimulus, stream models and checks
  //----------------------------------------------------------
  initial begin
    int              cycles;
    int              out_idx;
    int              src_idx;
    int              src_gap;
    int              mem_delay;
    int              pend_idx;
    logic            pending;
    logic            first_req;
    logic            req_fire;
    logic            resp_fire;
    logic            m2p_fire;
    logic            p2m_fire;
    proc_pkg::word_t last_addr;

    void'($urandom(32'h795acfd3));
    prog = '{
      read_mngr(1), read_mngr(2),
      reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLTU, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SRL_SRA, 3, 1, 2), write_mngr(3),
      reg_op(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SRL_SRA, 3, 1, 2), write_mngr(3),
      imm_op(rv_isa_pkg::F3_ADD_SUB, 4, 0, -5), write_mngr(4),
      imm_op(rv_isa_pkg::F3_AND, 5, 1, -256), write_mngr(5),
      imm_op(rv_isa_pkg::F3_OR, 5, 2, 12'h100), write_mngr(5),
      imm_op(rv_isa_pkg::F3_XOR, 5, 1, -1), write_mngr(5),
      imm_op(rv_isa_pkg::F3_SLT, 5, 1, -1), write_mngr(5),
      imm_op(rv_isa_pkg::F3_SLTU, 5, 2, -1), write_mngr(5),
      shift_imm(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL, 5, 2, 3), write_mngr(5),
      shift_imm(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SRL_SRA, 5, 1, 8), write_mngr(5),
      shift_imm(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SRL_SRA, 5, 1, 8), write_mngr(5),
      upper_imm(rv_isa_pkg::OPC_LUI, 6, 20'h12345), write_mngr(6),
      // AUIPC sits at 0x2a8
      upper_imm(rv_isa_pkg::OPC_AUIPC, 6, 20'h00001), write_mngr(6),
      imm_op(rv_isa_pkg::F3_ADD_SUB, 0, 0, 5), write_mngr(0),
      // x8 marks a skipped path and x9 a fall-through
      imm_op(rv_isa_pkg::F3_ADD_SUB, 8, 0, 12'h5ad),
      imm_op(rv_isa_pkg::F3_ADD_SUB, 9, 0, 12'h0f1),
      branch_op(rv_isa_pkg::F3_BEQ, 1, 1, 8), write_mngr(8),
      branch_op(rv_isa_pkg::F3_BEQ, 1, 2, 8), write_mngr(9),
      branch_op(rv_isa_pkg::F3_BNE, 1, 2, 8), write_mngr(8),
      branch_op(rv_isa_pkg::F3_BNE, 1, 1, 8), write_mngr(9),
      branch_op(rv_isa_pkg::F3_BLT, 1, 2, 8), write_mngr(8),
      branch_op(rv_isa_pkg::F3_BLT, 2, 1, 8), write_mngr(9),
      branch_op(rv_isa_pkg::F3_BGE, 2, 1, 8), write_mngr(8),
      branch_op(rv_isa_pkg::F3_BGE, 1, 2, 8), write_mngr(9),
      branch_op(rv_isa_pkg::F3_BLTU, 2, 1, 8), write_mngr(8),
      branch_op(rv_isa_pkg::F3_BLTU, 1, 2, 8), write_mngr(9),
      branch_op(rv_isa_pkg::F3_BGEU, 1, 2, 8), write_mngr(8),
      branch_op(rv_isa_pkg::F3_BGEU, 2, 1, 8), write_mngr(9),
      jal_op(10, 8), write_mngr(8), write_mngr(10),
      // Target 0x32c + 13 lands on 0x338 once bit 0 is cleared
      upper_imm(rv_isa_pkg::OPC_AUIPC, 12, 20'h0), jalr_op(11, 12, 13),
      write_mngr(8), write_mngr(11),
      jal_op(0, 0)
    };

    imem_req_rdy   = 1'b0;
    imem_resp_val  = 1'b0;
    imem_resp_data = '0;
    mngr2proc_val  = 1'b0;
    mngr2proc_msg  = '0;
    proc2mngr_rdy  = 1'b0;
    cycles    = 0;
    out_idx   = 0;
    src_idx   = 0;
    src_gap   = 0;
    mem_delay = 0;
    pend_idx  = 0;
    pending   = 1'b0;
    first_req = 1'b1;
    req_fire  = 1'b0;
    resp_fire = 1'b0;
    m2p_fire  = 1'b0;
    p2m_fire  = 1'b0;
    last_addr = RESET_PC;

    // Control outputs stay low while reset is held
    @(negedge clk);
    while (reset) begin
      check_value("imem_req_val_o", imem_req_val, 0);
      check_value("imem_resp_rdy_o", imem_resp_rdy, 0);
      check_value("mngr2proc_rdy_o", mngr2proc_rdy, 0);
      check_value("proc2mngr_val_o", proc2mngr_val, 0);
      @(negedge clk);
    end

    while (out_idx < NUM_OUTS) begin
      @(posedge clk);
      #1;
      // Memory model with one request in flight
      if (resp_fire) begin
        pending       = 1'b0;
        imem_resp_val = 1'b0;
      end
      if (req_fire) begin
        pending   = 1'b1;
        mem_delay = $urandom % 4;
      end
      if (pending && !imem_resp_val) begin
        if (mem_delay == 0) begin
          imem_resp_val  = 1'b1;
          imem_resp_data = prog[pend_idx];
        end else begin
          mem_delay--;
        end
      end
      imem_req_rdy = ($urandom % 2) == 1;

      // Manager source with random gaps
      if (m2p_fire) begin
        src_idx++;
        mngr2proc_val = 1'b0;
        src_gap       = $urandom % 3;
      end
      if (!mngr2proc_val && src_idx < NUM_SRC) begin
        if (src_gap == 0) begin
          mngr2proc_val = 1'b1;
          mngr2proc_msg = mngr_in[src_idx];
        end else begin
          src_gap--;
        end
      end
      proc2mngr_rdy = ($urandom % 4) != 0;

      // Nothing changes between here and the next rising edge
      @(negedge clk);
      cycles++;
      if (cycles > MAX_CYCLES) begin
        $display("Timeout: only %0d of %0d outputs seen after %0d cycles",
                 out_idx, NUM_OUTS, cycles);
        $display("TEST FAILED");
        $fatal(1);
      end
      req_fire  = imem_req_val && imem_req_rdy;
      resp_fire = imem_resp_val && imem_resp_rdy;
      m2p_fire  = mngr2proc_val && mngr2proc_rdy;
      p2m_fire  = proc2mngr_val && proc2mngr_rdy;

      if (req_fire) begin
        if (imem_req_addr < RESET_PC || imem_req_addr >= RESET_PC + 4 * NUM_INSTS ||
            imem_req_addr[1:0] != 2'b00) begin
          $display("Instruction fetch from address %h is outside the program", imem_req_addr);
          $display("TEST FAILED");
          $fatal(1);
        end
        if (first_req) begin
          check_value("imem_req_addr_o", imem_req_addr, RESET_PC);
          first_req = 1'b0;
        end else begin
          check_value("imem_req_addr_o", imem_req_addr, next_fetch(last_addr));
        end
        last_addr = imem_req_addr;
        pend_idx  = (imem_req_addr - RESET_PC) >> 2;
      end
      if (p2m_fire) begin
        check_value("proc2mngr_msg_o", proc2mngr_msg, exp_out[out_idx]);
        out_idx++;
      end
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: proc_top.f
hw/rv_isa_pkg.sv
hw/proc_pkg.sv
hw/inst_decoder.sv
hw/alu.sv
hw/reg_file.sv
hw/proc_ctrl.sv
hw/proc_top.sv
verification/tb_clk_gen.sv
verification/proc_top_tb.sv
